// ==== test/router_golden.hex ====
// in_port dest_x dest_y payload exp_port stall, hex; ports 0 local 1 north 2 east 3 south 4 west
// payload[15:13] is the source port, payload[12:0] a sequence number; a line with port f ends it
0 1 1 0001 0 0
0 1 0 0002 1 0
0 2 1 0003 2 0
0 1 2 0004 3 0
0 0 1 0005 4 0
0 3 3 0006 2 0
0 1 3 0007 3 0
0 0 0 0008 4 0
0 2 0 0009 2 0
0 1 1 000a 0 0
0 0 3 000b 4 0
0 1 0 000c 1 0
1 2 1 2001 2 0
1 3 0 2002 2 0
1 2 2 2003 2 0
1 3 3 2004 2 0
1 2 0 2005 2 0
1 3 1 2006 2 0
1 2 3 2007 2 0
1 3 2 2008 2 0
1 2 1 2009 2 0
1 3 0 200a 2 0
1 2 2 200b 2 0
1 3 3 200c 2 0
3 2 2 6001 2 0
3 3 1 6002 2 0
3 2 3 6003 2 0
3 3 0 6004 2 0
3 2 1 6005 2 0
3 3 2 6006 2 0
3 2 0 6007 2 0
3 3 3 6008 2 0
3 2 2 6009 2 0
3 3 1 600a 2 0
3 2 3 600b 2 0
3 3 0 600c 2 0
2 0 1 4001 4 1
2 0 0 4002 4 1
2 0 2 4003 4 1
2 0 3 4004 4 1
2 0 1 4005 4 1
2 0 0 4006 4 1
2 0 2 4007 4 1
2 0 3 4008 4 1
2 0 1 4009 4 1
2 0 0 400a 4 1
2 0 2 400b 4 1
2 0 3 400c 4 1
2 0 1 400d 4 1
2 0 0 400e 4 1
4 1 1 8001 0 0
4 1 0 8002 1 0
4 1 2 8003 3 0
4 2 1 8004 2 0
4 1 3 8005 3 0
4 1 1 8006 0 0
4 3 2 8007 2 0
4 1 0 8008 1 0
4 1 2 8009 3 0
4 1 1 800a 0 0
4 2 3 800b 2 0
4 1 0 800c 1 0
f 0 0 0000 0 0

// ==== list.f ====
hw/noc_pkg.sv
hw/queue_port_if.sv
hw/input_unit.sv
hw/switch_allocator.sv
hw/output_unit.sv
hw/mesh_router.sv
test/router_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module router_tb \
    -f list.f \
    -o router_sim

./obj_dir/router_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failure"

// ==== test/router_tb.sv ====
`timescale 1ns/1ps

module router_tb;

    import noc_pkg::*;

    localparam int DEPTH        = 4;
    localparam int MAX_LINES    = 128;
    localparam int FIELDS       = 6;
    localparam int STALL_CYCLES = 100;
    localparam int FAIR_A       = 1;
    localparam int FAIR_B       = 3;
    localparam int FAIR_OUT     = 2;

    logic                 clk;
    logic                 rst_n;
    flit_t                in_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] credit_out;
    flit_t                out_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] credit_in;

    logic [15:0] golden [0:MAX_LINES*FIELDS-1];
    flit_t       send_q [NUM_PORTS][$];
    flit_t       exp_q [NUM_PORTS*NUM_PORTS][$];

    int     n_lines;
    int     lines_per_in [NUM_PORTS];
    int     flits_to [NUM_PORTS];
    logic   stall_out [NUM_PORTS];
    int     tx_credits [NUM_PORTS];
    int     sent [NUM_PORTS];
    int     credit_pulses [NUM_PORTS];
    int     owed [NUM_PORTS];
    int     gap [NUM_PORTS];
    int     stall_seen [NUM_PORTS];
    int     arrived;
    int     cycle;
    int     fair_last;
    int     n_checks;
    int     n_errors;
    integer seed;
    bit     running;
    bit     loaded;

    mesh_router #(
        .QUEUE_DEPTH (DEPTH),
        .ROUTER_X    (1),
        .ROUTER_Y    (1)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_flit    (in_flit),
        .credit_out (credit_out),
        .out_flit   (out_flit),
        .credit_in  (credit_in)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic note_error(input string what);
        n_errors++;
        $display("error: %s", what);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // six fields per line, end marker has port f.
    task automatic load_golden();
        int    base;
        int    src;
        int    outp;
        flit_t f;
        $readmemh("test/router_golden.hex", golden);
        n_lines = 0;
        while (n_lines < MAX_LINES && !$isunknown(golden[n_lines*FIELDS]) &&
               golden[n_lines*FIELDS] != 16'h000f) begin
            base      = n_lines * FIELDS;
            f.valid   = 1'b1;
            f.dest_x  = golden[base+1][COORD_W-1:0];
            f.dest_y  = golden[base+2][COORD_W-1:0];
            f.payload = golden[base+3];
            src       = int'(golden[base][2:0]);
            outp      = int'(golden[base+4][2:0]);
            if (src >= NUM_PORTS || outp >= NUM_PORTS ||
                src != int'(f.payload[PAYLOAD_W-1:PAYLOAD_W-3])) begin
                note_error($sformatf("golden line %0d has a bad port field", n_lines));
            end else begin
                send_q[src].push_back(f);
                exp_q[src*NUM_PORTS + outp].push_back(f);
                lines_per_in[src]++;
                flits_to[outp]++;
                if (golden[base+5][0]) begin
                    stall_out[outp] = 1'b1;
                end
            end
            n_lines++;
        end
    endtask

    // falling edge: count credits, drive flits, score outputs, return credits.
    always @(negedge clk) begin
        int src;
        int other;
        flit_t exp_f;
        if (running) begin
            cycle++;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (credit_out[i]) begin
                    credit_pulses[i]++;
                    tx_credits[i]++;
                    if (tx_credits[i] > DEPTH) begin
                        note_error($sformatf("input %0d returned more credits than sent", i));
                    end
                end
                if (send_q[i].size() > 0 && tx_credits[i] > 0) begin
                    in_flit[i] = send_q[i].pop_front();
                    tx_credits[i]--;
                    sent[i]++;
                end else begin
                    in_flit[i] = '0;
                end
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                credit_in[o] = 1'b0;
                if (out_flit[o].valid) begin
                    owed[o]++;
                    arrived++;
                    src = int'(out_flit[o].payload[PAYLOAD_W-1:PAYLOAD_W-3]);
                    if (src >= NUM_PORTS || exp_q[src*NUM_PORTS + o].size() == 0) begin
                        note_error($sformatf("unexpected flit %h on output %0d",
                                             out_flit[o].payload, o));
                    end else begin
                        exp_f = exp_q[src*NUM_PORTS + o].pop_front();
                        check_value($sformatf("out_flit[%0d].payload", o),
                                    out_flit[o].payload, exp_f.payload);
                        check_value($sformatf("out_flit[%0d].dest_x", o),
                                    out_flit[o].dest_x, exp_f.dest_x);
                        check_value($sformatf("out_flit[%0d].dest_y", o),
                                    out_flit[o].dest_y, exp_f.dest_y);
                    end
                    if (stall_out[o] && cycle <= STALL_CYCLES) begin
                        stall_seen[o]++;
                    end
                    // both backlogged inputs must take turns.
                    if (o == FAIR_OUT && (src == FAIR_A || src == FAIR_B)) begin
                        other = (src == FAIR_A) ? FAIR_B : FAIR_A;
                        if (fair_last == src && exp_q[other*NUM_PORTS + o].size() > 0) begin
                            note_error($sformatf("input %0d served twice in a row on output %0d",
                                                 src, o));
                        end
                        fair_last = src;
                    end
                end
                if (!(stall_out[o] && cycle <= STALL_CYCLES) && owed[o] > 0) begin
                    if (gap[o] == 0) begin
                        credit_in[o] = 1'b1;
                        owed[o]--;
                        gap[o] = $unsigned($random(seed)) % 4;
                    end else begin
                        gap[o]--;
                    end
                end
            end
            if (cycle == STALL_CYCLES) begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                    if (stall_out[o]) begin
                        check_value($sformatf("out_flit[%0d] count while stalled", o),
                                    stall_seen[o], (flits_to[o] < DEPTH) ? flits_to[o] : DEPTH);
                    end
                end
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        credit_in = '0;
        running   = 1'b0;
        loaded    = 1'b0;
        seed      = 65;
        arrived   = 0;
        cycle     = 0;
        fair_last = -1;
        n_checks  = 0;
        n_errors  = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_flit[i]       = '0;
            lines_per_in[i]  = 0;
            flits_to[i]      = 0;
            stall_out[i]     = 1'b0;
            tx_credits[i]    = DEPTH;
            sent[i]          = 0;
            credit_pulses[i] = 0;
            owed[i]          = 0;
            gap[i]           = 0;
            stall_seen[i]    = 0;
        end
        load_golden();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        // outputs as left by reset.
        for (int o = 0; o < NUM_PORTS; o++) begin
            check_value($sformatf("out_flit[%0d].valid", o), out_flit[o].valid, 0);
            check_value($sformatf("credit_out[%0d]", o), credit_out[o], 0);
        end
        rst_n = 1'b1;
        @(posedge clk);
        running = 1'b1;
        wait (arrived == n_lines);
        repeat (4) @(negedge clk);
        for (int i = 0; i < NUM_PORTS; i++) begin
            check_value($sformatf("flits sent on in_flit[%0d]", i), sent[i], lines_per_in[i]);
            check_value($sformatf("credit_out[%0d] pulses", i), credit_pulses[i], sent[i]);
            check_value($sformatf("input %0d credit count", i), tx_credits[i], DEPTH);
        end
        for (int k = 0; k < NUM_PORTS*NUM_PORTS; k++) begin
            if (exp_q[k].size() != 0) begin
                note_error($sformatf("%0d flits from input %0d never left output %0d",
                                     exp_q[k].size(), k / NUM_PORTS, k % NUM_PORTS));
            end
        end
        finish_run();
    end

    // watchdog scaled by the golden file length.
    initial begin
        wait (loaded);
        repeat (n_lines * 50 + 200) @(posedge clk);
        note_error($sformatf("timeout with %0d of %0d flits delivered", arrived, n_lines));
        finish_run();
    end

endmodule

// ==== hw/mesh_router.sv ====
`timescale 1ns/1ps

module mesh_router #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ROUTER_X    = 1,
    parameter int ROUTER_Y    = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  noc_pkg::flit_t                in_flit [noc_pkg::NUM_PORTS],
    output logic [noc_pkg::NUM_PORTS-1:0] credit_out,
    output noc_pkg::flit_t                out_flit [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::NUM_PORTS-1:0] credit_in
);

    import noc_pkg::*;

    logic  [NUM_PORTS-1:0] credit_ok;
    logic  [NUM_PORTS-1:0] send;
    flit_t                 send_flit [NUM_PORTS];

    queue_port_if qp [NUM_PORTS] ();

    // input side.
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_input
        input_unit #(
            .QUEUE_DEPTH (QUEUE_DEPTH),
            .ROUTER_X    (ROUTER_X),
            .ROUTER_Y    (ROUTER_Y)
        ) u_input (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_flit    (in_flit[i]),
            .credit_out (credit_out[i]),
            .qp         (qp[i])
        );
    end

    switch_allocator u_alloc (
        .clk       (clk),
        .rst_n     (rst_n),
        .qp        (qp),
        .credit_ok (credit_ok),
        .send      (send),
        .send_flit (send_flit)
    );

    // output side.
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_output
        output_unit #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) u_output (
            .clk       (clk),
            .rst_n     (rst_n),
            .send      (send[o]),
            .send_flit (send_flit[o]),
            .credit_in (credit_in[o]),
            .credit_ok (credit_ok[o]),
            .out_flit  (out_flit[o])
        );
    end

endmodule

// ==== hw/output_unit.sv ====
`timescale 1ns/1ps

module output_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           send,
    input  noc_pkg::flit_t send_flit,
    input  logic           credit_in,
    output logic           credit_ok,
    output noc_pkg::flit_t out_flit
);

    import noc_pkg::*;

    localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [CRED_W-1:0] CRED_FULL = CRED_W'(QUEUE_DEPTH);

    logic                 valid_q;
    logic [COORD_W-1:0]   dest_x_q;
    logic [COORD_W-1:0]   dest_y_q;
    logic [PAYLOAD_W-1:0] payload_q;
    logic [CRED_W-1:0]    credit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            dest_x_q  <= send_flit.dest_x;
            dest_y_q  <= send_flit.dest_y;
            payload_q <= send_flit.payload;
        end
    end

    assign out_flit = '{valid: valid_q, dest_x: dest_x_q, dest_y: dest_y_q, payload: payload_q};

    // free slots in the downstream queue.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= CRED_FULL;
        end else begin
            case ({send, credit_in})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    assign credit_ok = credit != '0;

    // a granted flit always has a free downstream slot.
    a_send_has_credit: assert property (
        @(posedge clk) disable iff (!rst_n) send |-> (credit != '0)
    );

    // downstream never returns more slots than it has.
    a_credit_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) (credit_in && !send) |-> (credit < CRED_FULL)
    );

endmodule

// ==== hw/switch_allocator.sv ====
`timescale 1ns/1ps

module switch_allocator (
    input  logic                            clk,
    input  logic                            rst_n,
    queue_port_if.sink                      qp [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::NUM_PORTS-1:0]   credit_ok,
    output logic [noc_pkg::NUM_PORTS-1:0]   send,
    output noc_pkg::flit_t                  send_flit [noc_pkg::NUM_PORTS]
);

    import noc_pkg::*;

    localparam int PORT_W = $clog2(NUM_PORTS);

    flit_t                                 head [NUM_PORTS];
    logic  [NUM_PORTS-1:0]                 head_valid;
    port_e                                 route [NUM_PORTS];
    logic  [NUM_PORTS-1:0]                 pop;
    logic  [NUM_PORTS-1:0][NUM_PORTS-1:0]  req;
    logic  [NUM_PORTS-1:0][NUM_PORTS-1:0]  grant;
    logic  [PORT_W-1:0]                    win [NUM_PORTS];
    logic  [PORT_W-1:0]                    rr_ptr [NUM_PORTS];

    // flatten the interface array.
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        assign head[i]       = qp[i].head;
        assign head_valid[i] = qp[i].head_valid;
        assign route[i]      = qp[i].route;
        assign qp[i].pop     = pop[i];
    end

    // requests indexed [output][input].
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                req[o][i] = head_valid[i] && (route[i] == port_e'(o));
            end
        end
    end

    // round-robin search; walked backwards so the first hit at or after the pointer wins.
    always_comb begin
        int idx;
        for (int o = 0; o < NUM_PORTS; o++) begin
            grant[o] = '0;
            win[o]   = '0;
            for (int k = NUM_PORTS - 1; k >= 0; k--) begin
                idx = int'(rr_ptr[o]) + k;
                if (idx >= NUM_PORTS) begin
                    idx = idx - NUM_PORTS;
                end
                if (req[o][idx]) begin
                    grant[o]      = '0;
                    grant[o][idx] = 1'b1;
                    win[o]        = PORT_W'(idx);
                end
            end
            if (!credit_ok[o]) begin
                grant[o] = '0;
            end
        end
    end

    // an input routes to one output only, so at most one grant per input.
    always_comb begin
        pop = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            pop = pop | grant[o];
        end
    end

    // crossbar.
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            send[o]      = |grant[o];
            send_flit[o] = send[o] ? head[win[o]] : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                rr_ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (send[o]) begin
                    rr_ptr[o] <= (win[o] == PORT_W'(NUM_PORTS - 1)) ? '0 : win[o] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/input_unit.sv ====
`timescale 1ns/1ps

module input_unit #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ROUTER_X    = 1,
    parameter int ROUTER_Y    = 1
) (
    input  logic           clk,
    input  logic           rst_n,
    input  noc_pkg::flit_t in_flit,
    output logic           credit_out,
    queue_port_if.source   qp
);

    import noc_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [COORD_W-1:0] MY_X = COORD_W'(ROUTER_X);
    localparam logic [COORD_W-1:0] MY_Y = COORD_W'(ROUTER_Y);

    logic [FLIT_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_next;
    logic [PTR_W-1:0]  rd_next;
    logic              empty;
    logic              avail;
    logic              wr_en;
    port_e             route_c;

    assign wr_next = (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_next = (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    assign wr_en   = in_flit.valid && avail;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // write / shift case table on {valid, avail, pop, empty}.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            empty  <= 1'b1;
            avail  <= 1'b1;
        end else begin
            casez ({in_flit.valid, avail, qp.pop, empty})
                4'b1100, 4'b1101, 4'b1111: begin
                    wr_ptr <= wr_next;
                    avail  <= wr_next != rd_ptr;
                    empty  <= 1'b0;
                end
                4'b1110: begin
                    wr_ptr <= wr_next;
                    rd_ptr <= rd_next;
                end
                4'b1010, 4'b0?10: begin
                    rd_ptr <= rd_next;
                    avail  <= 1'b1;
                    empty  <= wr_ptr == rd_next;
                end
                default: begin
                end
            endcase
        end
    end

    assign qp.head       = empty ? '0 : flit_t'(mem[rd_ptr]);
    assign qp.head_valid = !empty;

    // XY routing, x resolved first.
    always_comb begin
        if (qp.head.dest_x > MY_X) begin
            route_c = port_east;
        end else if (qp.head.dest_x < MY_X) begin
            route_c = port_west;
        end else if (qp.head.dest_y > MY_Y) begin
            route_c = port_south;
        end else if (qp.head.dest_y < MY_Y) begin
            route_c = port_north;
        end else begin
            route_c = port_local;
        end
    end

    assign qp.route = route_c;

    // one credit back upstream per freed slot.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_out <= 1'b0;
        end else begin
            credit_out <= qp.pop;
        end
    end

    // upstream must hold a credit for every flit it sends.
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) in_flit.valid |-> avail
    );

endmodule

// ==== hw/queue_port_if.sv ====
`timescale 1ns/1ps

interface queue_port_if;

    import noc_pkg::*;

    // head of the input queue and its computed route.
    flit_t head;
    logic  head_valid;
    port_e route;

    // removes the head at the next edge.
    logic  pop;

    modport source (
        output head,
        output head_valid,
        output route,
        input  pop
    );

    modport sink (
        input  head,
        input  head_valid,
        input  route,
        output pop
    );

endinterface

// ==== hw/noc_pkg.sv ====
package noc_pkg;

    // one mesh coordinate, 4x4 mesh.
    localparam int COORD_W = 2;

    // upper 3 bits source port, low 13 bits sequence number.
    localparam int PAYLOAD_W = 16;

    localparam int NUM_PORTS = 5;

    // router directions, used for both inputs and outputs.
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_north = 3'd1,
        port_east  = 3'd2,
        port_south = 3'd3,
        port_west  = 3'd4
    } port_e;

    // single-flit packet.
    typedef struct packed {
        logic                 valid;
        logic [COORD_W-1:0]   dest_x;
        logic [COORD_W-1:0]   dest_y;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    localparam int FLIT_W = $bits(flit_t);

endpackage
